//--- filelist.f
source/isa_pkg.sv
source/mem_pkg.sv
source/mem_sequencer.sv
source/operand_slot.sv
source/mem_credit_port.sv
source/mem_manager.sv
verif/tb_clock.sv
verif/mem_manager_props.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the regression, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -o sim_tb \
  -f filelist.f || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^Regression passed$" sim.log && exit 0 || exit 1

//--- verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import isa_pkg::*;
  import mem_pkg::*;

  localparam int CREDITS = 2;
  // five tests, up to eight commands each, 100 cycles per command
  localparam int TIMEOUT_CYCLES = 4000;
  localparam addr_t CODE_BASE = 32'h100;
  localparam addr_t REG_BASE = 32'h300;

  logic clk;
  logic rst_init;
  logic rst_test = 1'b1;
  logic rst;
  addr_t code_base = CODE_BASE;
  addr_t reg_base = REG_BASE;
  logic mem_req_valid, mem_req_write;
  addr_t mem_req_addr;
  data_t mem_req_data;
  logic mem_credit = 1'b0;
  logic mem_rsp_valid = 1'b0;
  data_t mem_rsp_data = '0;
  logic op_valid;
  cmd_code_t op_code;
  data_t op_src1, op_src0;
  logic res_valid = 1'b0;
  data_t res_data = '0;
  logic halted;

  assign rst = rst_init | rst_test;

  tb_clock clkgen (.clk(clk), .rst(rst_init));

  mem_manager #(.MEM_CREDITS(CREDITS)) dut0 (
    .clk, .rst, .code_base, .reg_base,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_data,
    .mem_credit, .mem_rsp_valid, .mem_rsp_data,
    .op_valid, .op_code, .op_src1, .op_src0, .res_valid, .res_data, .halted
  );

  bind mem_credit_port mem_manager_props #(.MEM_CREDITS(MEM_CREDITS)) props0 (
    .clk(clk), .rst(rst), .mem_req_valid(mem_req_valid),
    .mem_credit(mem_credit), .credits(credits)
  );

  // memory image, preload list and model bookkeeping
  data_t mem [0:1023];
  addr_t load_a [0:63];
  data_t load_d [0:63];
  int load_n = 0;
  int fill_gen = 0;
  int credit_max_delay = 3;
  int rsp_due[$];
  data_t rsp_q[$];
  int credit_due[$];
  int cycle = 0;
  int rd_count = 0;
  int req_count = 0;
  int overruns = 0;
  // executor log, one entry per operation
  cmd_code_t log_code[$];
  data_t log_src1[$];
  data_t log_src0[$];
  int log_base, rd_base, ovr_base;
  int errors = 0;
  int checks = 0;
  int run_cycles = 0;
  int seed;

  // in-order memory, variable read latency, delayed credit return
  always @(posedge clk) begin : mem_model
    logic req_v, req_w, crd;
    addr_t req_a;
    data_t req_d;
    int due;
    int fill_seen;
    int load_done;
    int outstanding;
    req_v = mem_req_valid;
    req_w = mem_req_write;
    req_a = mem_req_addr;
    req_d = mem_req_data;
    crd = mem_credit;
    cycle++;
    if (fill_gen != fill_seen) begin
      for (int i = 0; i < 1024; i++) mem[i] = 32'h5a5a_0000 ^ data_t'(i);
      fill_seen = fill_gen;
      load_done = 0;
    end
    while (load_done < load_n) begin
      mem[load_a[load_done][9:0]] = load_d[load_done];
      load_done++;
    end
    if (rst) begin
      rsp_due.delete();
      rsp_q.delete();
      credit_due.delete();
      outstanding = 0;
      #1;
      mem_rsp_valid = 1'b0;
      mem_credit = 1'b0;
    end else begin
      // requests in flight against credits handed out
      outstanding = outstanding + int'(req_v) - int'(crd);
      if (outstanding > CREDITS) overruns++;
      if (req_v) begin
        req_count++;
        if (req_w) begin
          mem[req_a[9:0]] = req_d;
        end else begin
          rd_count++;
          due = cycle + 1 + int'($urandom % 4);
          // keep answers in request order
          if (rsp_due.size() > 0 && due <= rsp_due[$]) due = rsp_due[$] + 1;
          rsp_due.push_back(due);
          rsp_q.push_back(mem[req_a[9:0]]);
        end
        credit_due.push_back(cycle + 1 + int'($urandom % credit_max_delay));
      end
      #1;
      mem_rsp_valid = 1'b0;
      mem_credit = 1'b0;
      if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
        void'(rsp_due.pop_front());
        mem_rsp_data = rsp_q.pop_front();
        mem_rsp_valid = 1'b1;
      end
      if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
        void'(credit_due.pop_front());
        mem_credit = 1'b1;
      end
    end
  end

  function automatic data_t alu(cmd_code_t c, data_t a, data_t b);
    case (c)
      CMD_MOV: return a;
      CMD_ADD: return a + b;
      CMD_SUB: return a - b;
      CMD_AND: return a & b;
      default: return '0;
    endcase
  endfunction

  // executor: phase 0 idle, 1 computing, 2 waiting for op_valid to drop
  always @(posedge clk) begin : exec_model
    logic v;
    logic fire;
    cmd_code_t c;
    data_t a, b;
    int phase;
    int cnt;
    v = op_valid;
    c = op_code;
    a = op_src1;
    b = op_src0;
    fire = 1'b0;
    if (rst) begin
      phase = 0;
    end else begin
      case (phase)
        0: if (v) begin
          log_code.push_back(c);
          log_src1.push_back(a);
          log_src0.push_back(b);
          cnt = 1 + int'($urandom % 3);
          phase = 1;
        end
        1: begin
          cnt--;
          if (cnt == 0) begin
            fire = 1'b1;
            phase = 2;
          end
        end
        default: if (!v) phase = 0;
      endcase
    end
    #1;
    res_valid = fire;
    if (fire) res_data = alu(c, a, b);
  end

  always @(posedge clk) begin
    run_cycles++;
    if (run_cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: DUT did not finish the tests within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic check_data(string name, data_t exp, data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_code(string name, cmd_code_t exp, cmd_code_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  function automatic data_t make_cmd(cmd_code_t code, int dst, int src0, int src1,
                                     bit dp, bit s0p, bit s1p);
    data_t w;
    w = '0;
    w[31:28] = code;
    w[18] = dp;
    w[17] = s0p;
    w[16] = s1p;
    w[11:8] = dst[3:0];
    w[7:4] = src0[3:0];
    w[3:0] = src1[3:0];
    return w;
  endfunction

  task automatic poke(addr_t a, data_t d);
    load_a[load_n] = a;
    load_d[load_n] = d;
    load_n++;
  endtask

  task automatic set_reg(int n, data_t d);
    poke(REG_BASE + addr_t'(n), d);
  endtask

  function automatic data_t peek(addr_t a);
    return mem[a[9:0]];
  endfunction

  function automatic data_t get_reg(int n);
    return peek(REG_BASE + addr_t'(n));
  endfunction

  // hold reset, refill memory, note where the counters start
  task automatic begin_test;
    @(posedge clk);
    #1 rst_test = 1'b1;
    fill_gen++;
    load_n = 0;
    credit_max_delay = 3;
    log_base = log_code.size();
    rd_base = rd_count;
    ovr_base = overruns;
  endtask

  task automatic run_program(string name);
    int q;
    repeat (16) @(posedge clk);
    #1 rst_test = 1'b0;
    while (!halted) @(posedge clk);
    q = req_count;
    repeat (30) @(posedge clk);
    check_count({name, " halted"}, 1, int'(halted));
    check_count({name, " requests after halt"}, 0, req_count - q);
  endtask

  task automatic check_op(string name, int idx, cmd_code_t c, data_t s1, data_t s0);
    if (log_code.size() > log_base + idx) begin
      check_code({name, " code"}, c, log_code[log_base + idx]);
      check_data({name, " src1"}, s1, log_src1[log_base + idx]);
      check_data({name, " src0"}, s0, log_src0[log_base + idx]);
    end else begin
      errors++;
      $display("%s: the executor never received operation %0d", name, idx);
    end
  endtask

  // add and subtract on direct registers, shared with the credit test
  task automatic alu_program(string name, data_t a, data_t b);
    set_reg(1, a);
    set_reg(2, b);
    set_reg(15, 32'd0);
    poke(CODE_BASE + 32'd0, make_cmd(CMD_ADD, 3, 2, 1, 0, 0, 0));
    poke(CODE_BASE + 32'd1, make_cmd(CMD_SUB, 4, 2, 1, 0, 0, 0));
    poke(CODE_BASE + 32'd2, make_cmd(CMD_HALT, 0, 0, 0, 0, 0, 0));
    run_program(name);
    check_count({name, " ops"}, 2, log_code.size() - log_base);
    check_op({name, " op0"}, 0, CMD_ADD, a, b);
    check_op({name, " op1"}, 1, CMD_SUB, a, b);
    check_data({name, " r3"}, a + b, get_reg(3));
    check_data({name, " r4"}, a - b, get_reg(4));
    check_data({name, " ip"}, 32'd2, get_reg(15));
  endtask

  task automatic test_direct;
    begin_test();
    alu_program("direct", $urandom, $urandom);
  endtask

  task automatic test_pointer;
    data_t a, b;
    a = $urandom;
    b = $urandom;
    begin_test();
    set_reg(1, 32'h200);
    set_reg(2, 32'h201);
    set_reg(5, 32'h210);
    set_reg(15, 32'd0);
    poke(32'h200, a);
    poke(32'h201, b);
    poke(CODE_BASE + 32'd0, make_cmd(CMD_ADD, 5, 2, 1, 1, 1, 1));
    poke(CODE_BASE + 32'd1, make_cmd(CMD_HALT, 0, 0, 0, 0, 0, 0));
    run_program("pointer");
    check_op("pointer op0", 0, CMD_ADD, a, b);
    check_data("pointer target", a + b, peek(32'h210));
    check_data("pointer r5", 32'h210, get_reg(5));
    check_data("pointer ip", 32'd1, get_reg(15));
  endtask

  task automatic test_forward;
    data_t a, b;
    a = $urandom;
    b = $urandom;
    begin_test();
    set_reg(1, a);
    set_reg(2, b);
    set_reg(15, 32'd0);
    // shared register, then ip as src1, then ip as src0
    poke(CODE_BASE + 32'd0, make_cmd(CMD_ADD, 3, 1, 1, 0, 0, 0));
    poke(CODE_BASE + 32'd1, make_cmd(CMD_AND, 4, 2, 15, 0, 0, 0));
    poke(CODE_BASE + 32'd2, make_cmd(CMD_ADD, 6, 15, 2, 0, 0, 0));
    poke(CODE_BASE + 32'd3, make_cmd(CMD_HALT, 0, 0, 0, 0, 0, 0));
    run_program("forward");
    // ip and fetch per command plus one source read each
    check_count("forward reads", 11, rd_count - rd_base);
    check_op("forward op0", 0, CMD_ADD, a, a);
    check_op("forward op1", 1, CMD_AND, 32'd2, b);
    check_op("forward op2", 2, CMD_ADD, b, 32'd3);
    check_data("forward r3", a + a, get_reg(3));
    check_data("forward r4", 32'd2 & b, get_reg(4));
    check_data("forward r6", b + 32'd3, get_reg(6));
  endtask

  task automatic test_backpressure;
    begin_test();
    credit_max_delay = 20;
    alu_program("backpressure", $urandom, $urandom);
    check_count("backpressure overruns", 0, overruns - ovr_base);
  endtask

  task automatic test_jump_halt;
    data_t c;
    c = $urandom;
    begin_test();
    set_reg(1, 32'd4);
    set_reg(2, 32'd1);
    set_reg(3, c);
    set_reg(15, 32'd0);
    poke(CODE_BASE + 32'd0, make_cmd(CMD_ADD, 15, 2, 1, 0, 0, 0));
    // skipped words halt early if the jump is missed
    for (int i = 1; i < 5; i++) begin
      poke(CODE_BASE + addr_t'(i), make_cmd(CMD_HALT, 0, 0, 0, 0, 0, 0));
    end
    poke(CODE_BASE + 32'd5, make_cmd(CMD_MOV, 7, 3, 3, 0, 0, 0));
    poke(CODE_BASE + 32'd6, make_cmd(CMD_HALT, 0, 0, 0, 0, 0, 0));
    run_program("jump");
    check_count("jump ops", 2, log_code.size() - log_base);
    check_op("jump op1", 1, CMD_MOV, c, c);
    check_data("jump r7", c, get_reg(7));
    check_data("jump ip", 32'd6, get_reg(15));
    check_data("jump r1", 32'd4, get_reg(1));
  endtask

  initial begin
    seed = 28;
    void'($urandom(seed));
    test_direct();
    test_pointer();
    test_forward();
    test_backpressure();
    test_jump_halt();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/mem_manager_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_manager_props #(
  parameter int MEM_CREDITS = 2
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               mem_req_valid,
  input logic                               mem_credit,
  input logic [$clog2(MEM_CREDITS+1)-1:0]   credits
);

  localparam int CNT_W = $clog2(MEM_CREDITS + 1);

  // requests still holding a credit, seen from the memory side
  int in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(mem_req_valid) - int'(mem_credit);
    end
  end

  // a request never goes out with every credit already spent
  no_empty_request: assert property (
    @(posedge clk) disable iff (rst) mem_req_valid |-> in_flight < MEM_CREDITS
  ) else $error("memory request issued with no credit left");

  // returned pulses never push the count past the pool
  credit_limit: assert property (
    @(posedge clk) disable iff (rst) credits <= CNT_W'(MEM_CREDITS)
  ) else $error("credit count above the credit pool");

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // power-on reset, 16 cycles
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- source/mem_manager.sv
`timescale 1ns/1ps
`default_nettype none

module mem_manager #(
  parameter int MEM_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  mem_pkg::addr_t     code_base,
  input  mem_pkg::addr_t     reg_base,
  output logic               mem_req_valid,
  output logic               mem_req_write,
  output mem_pkg::addr_t     mem_req_addr,
  output mem_pkg::data_t     mem_req_data,
  input  logic               mem_credit,
  input  logic               mem_rsp_valid,
  input  mem_pkg::data_t     mem_rsp_data,
  output logic               op_valid,
  output isa_pkg::cmd_code_t op_code,
  output mem_pkg::data_t     op_src1,
  output mem_pkg::data_t     op_src0,
  input  logic               res_valid,
  input  mem_pkg::data_t     res_data,
  output logic               halted
);

  // slot commands and completion
  mem_pkg::slot_op_t cmd_op, src1_op, src0_op, dst_op;
  logic cmd_done, src1_done, src0_done, dst_done;

  // request groups towards the credit port
  logic cmd_req_valid, src1_req_valid, src0_req_valid, dst_req_valid;
  logic cmd_req_write, src1_req_write, src0_req_write, dst_req_write;
  mem_pkg::addr_t cmd_req_addr, src1_req_addr, src0_req_addr, dst_req_addr;
  mem_pkg::data_t cmd_req_data, src1_req_data, src0_req_data, dst_req_data;

  // shared return path
  logic req_ready;
  logic rsp_valid;
  mem_pkg::data_t rsp_data;

  // command word and ip held by the cmd slot
  mem_pkg::data_t cmd_word;
  mem_pkg::data_t cmd_ptr;
  mem_pkg::data_t ip_next;
  mem_pkg::data_t src1_ptr;
  mem_pkg::data_t src0_fwd;

  isa_pkg::reg_num_t src1_num, src0_num, dst_num;

  // register fields of the fetched command
  assign src1_num = cmd_word[isa_pkg::SRC1_POS +: isa_pkg::REG_W];
  assign src0_num = cmd_word[isa_pkg::SRC0_POS +: isa_pkg::REG_W];
  assign dst_num  = cmd_word[isa_pkg::DST_POS +: isa_pkg::REG_W];
  assign op_code  = isa_pkg::cmd_code_t'(cmd_word[isa_pkg::CODE_POS +: isa_pkg::CODE_W]);

  // ip after the fetch, written back and seen by sources on reg 15
  assign ip_next = cmd_ptr + 32'd1;

  // src0 takes src1's register word, or ip+1 when it names ip alone
  assign src0_fwd = (src0_num == isa_pkg::REG_IP) ? ip_next : src1_ptr;

  mem_sequencer seq (
    .clk, .rst,
    .cmd_word  (cmd_word),
    .cmd_done  (cmd_done),
    .src1_done (src1_done),
    .src0_done (src0_done),
    .dst_done  (dst_done),
    .res_valid (res_valid),
    .cmd_op    (cmd_op),
    .src1_op   (src1_op),
    .src0_op   (src0_op),
    .dst_op    (dst_op),
    .op_valid  (op_valid),
    .halted    (halted)
  );

  // value is the command word, ptr is ip
  operand_slot cmd_slot (
    .clk, .rst, .reg_base, .code_base,
    .req_ready, .rsp_valid, .rsp_data,
    .op         (cmd_op),
    .reg_num    (isa_pkg::REG_IP),
    .catch_data (ip_next),
    .wr_data    (ip_next),
    .value      (cmd_word),
    .ptr        (cmd_ptr),
    .req_valid  (cmd_req_valid),
    .req_write  (cmd_req_write),
    .req_addr   (cmd_req_addr),
    .req_data   (cmd_req_data),
    .op_done    (cmd_done)
  );

  operand_slot src1_slot (
    .clk, .rst, .reg_base, .code_base,
    .req_ready, .rsp_valid, .rsp_data,
    .op         (src1_op),
    .reg_num    (src1_num),
    .catch_data (ip_next),
    .wr_data    (res_data),
    .value      (op_src1),
    .ptr        (src1_ptr),
    .req_valid  (src1_req_valid),
    .req_write  (src1_req_write),
    .req_addr   (src1_req_addr),
    .req_data   (src1_req_data),
    .op_done    (src1_done)
  );

  operand_slot src0_slot (
    .clk, .rst, .reg_base, .code_base,
    .req_ready, .rsp_valid, .rsp_data,
    .op         (src0_op),
    .reg_num    (src0_num),
    .catch_data (src0_fwd),
    .wr_data    (res_data),
    .value      (op_src0),
    .ptr        (),
    .req_valid  (src0_req_valid),
    .req_write  (src0_req_write),
    .req_addr   (src0_req_addr),
    .req_data   (src0_req_data),
    .op_done    (src0_done)
  );

  // result enters through wr_data, held inside the slot
  operand_slot dst_slot (
    .clk, .rst, .reg_base, .code_base,
    .req_ready, .rsp_valid, .rsp_data,
    .op         (dst_op),
    .reg_num    (dst_num),
    .catch_data (ip_next),
    .wr_data    (res_data),
    .value      (),
    .ptr        (),
    .req_valid  (dst_req_valid),
    .req_write  (dst_req_write),
    .req_addr   (dst_req_addr),
    .req_data   (dst_req_data),
    .op_done    (dst_done)
  );

  mem_credit_port #(
    .MEM_CREDITS (MEM_CREDITS)
  ) port0 (
    .clk, .rst,
    .cmd_req_valid, .cmd_req_write, .cmd_req_addr, .cmd_req_data,
    .src1_req_valid, .src1_req_write, .src1_req_addr, .src1_req_data,
    .src0_req_valid, .src0_req_write, .src0_req_addr, .src0_req_data,
    .dst_req_valid, .dst_req_write, .dst_req_addr, .dst_req_data,
    .mem_credit, .mem_rsp_valid, .mem_rsp_data,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_data,
    .req_ready, .rsp_valid, .rsp_data
  );

endmodule

`default_nettype wire

//--- source/mem_credit_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_credit_port #(
  parameter int MEM_CREDITS = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_req_valid,
  input  logic           cmd_req_write,
  input  mem_pkg::addr_t cmd_req_addr,
  input  mem_pkg::data_t cmd_req_data,
  input  logic           src1_req_valid,
  input  logic           src1_req_write,
  input  mem_pkg::addr_t src1_req_addr,
  input  mem_pkg::data_t src1_req_data,
  input  logic           src0_req_valid,
  input  logic           src0_req_write,
  input  mem_pkg::addr_t src0_req_addr,
  input  mem_pkg::data_t src0_req_data,
  input  logic           dst_req_valid,
  input  logic           dst_req_write,
  input  mem_pkg::addr_t dst_req_addr,
  input  mem_pkg::data_t dst_req_data,
  input  logic           mem_credit,
  input  logic           mem_rsp_valid,
  input  mem_pkg::data_t mem_rsp_data,
  output logic           mem_req_valid,
  output logic           mem_req_write,
  output mem_pkg::addr_t mem_req_addr,
  output mem_pkg::data_t mem_req_data,
  output logic           req_ready,
  output logic           rsp_valid,
  output mem_pkg::data_t rsp_data
);
  import mem_pkg::*;

  // wide enough to hold the full credit count
  localparam int CNT_W = $clog2(MEM_CREDITS + 1);

  logic [CNT_W-1:0] credits;
  logic             any_valid;
  logic             any_write;

  // at most one slot asks at a time
  assign any_valid = cmd_req_valid | src1_req_valid | src0_req_valid | dst_req_valid;
  assign any_write = cmd_req_write | src1_req_write | src0_req_write | dst_req_write;

  assign req_ready = (credits != '0);

  // no credit, no request
  assign mem_req_valid = any_valid && req_ready;
  assign mem_req_write = any_write && req_ready;
  assign mem_req_addr  = cmd_req_addr | src1_req_addr | src0_req_addr | dst_req_addr;
  assign mem_req_data  = cmd_req_data | src1_req_data | src0_req_data | dst_req_data;

  // one credit out per request, one back per pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CNT_W'(MEM_CREDITS);
    end else begin
      credits <= credits - CNT_W'(mem_req_valid) + CNT_W'(mem_credit);
    end
  end

  // responses come back in order, straight to all slots
  assign rsp_valid = mem_rsp_valid;
  assign rsp_data  = mem_rsp_data;

endmodule

`default_nettype wire

//--- source/operand_slot.sv
`timescale 1ns/1ps
`default_nettype none

module operand_slot (
  input  logic              clk,
  input  logic              rst,
  input  mem_pkg::slot_op_t op,
  input  isa_pkg::reg_num_t reg_num,
  input  mem_pkg::addr_t    reg_base,
  input  mem_pkg::addr_t    code_base,
  input  mem_pkg::data_t    catch_data,
  input  mem_pkg::data_t    wr_data,
  input  logic              req_ready,
  input  logic              rsp_valid,
  input  mem_pkg::data_t    rsp_data,
  output mem_pkg::data_t    value,
  output mem_pkg::data_t    ptr,
  output logic              req_valid,
  output logic              req_write,
  output mem_pkg::addr_t    req_addr,
  output mem_pkg::data_t    req_data,
  output logic              op_done
);
  import isa_pkg::*;
  import mem_pkg::*;

  logic  is_read;
  logic  is_write;
  logic  by_ptr;
  logic  rd_wait;
  logic  rd_end;
  data_t wr_hold;
  addr_t reg_addr;
  addr_t ptr_addr;

  assign is_read  = (op == SLOT_READ) || (op == SLOT_READ_P);
  assign is_write = (op == SLOT_WRITE) || (op == SLOT_WRITE_P);
  assign by_ptr   = (op == SLOT_READ_P) || (op == SLOT_WRITE_P);

  // register word in the register file
  assign reg_addr = reg_base + addr_t'(reg_num);
  // a pointer held in ip points into the code area
  assign ptr_addr = (reg_num == REG_IP) ? code_base + addr_t'(ptr) : addr_t'(ptr);

  // read asks once and then waits, write asks until accepted
  assign req_valid = (is_read && !rd_wait) || is_write;
  assign req_write = is_write;
  // zero when idle so the port can OR the slots together
  assign req_addr  = req_valid ? (by_ptr ? ptr_addr : reg_addr) : '0;
  assign req_data  = is_write ? wr_hold : '0;

  // only the waiting slot owns the response
  assign rd_end = rd_wait && rsp_valid;

  always_comb begin
    case (op)
      SLOT_READ, SLOT_READ_P: op_done = rd_end;
      SLOT_CATCH: op_done = 1'b1;
      // accepted when a credit is there
      SLOT_WRITE, SLOT_WRITE_P: op_done = req_ready;
      default: op_done = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wait <= 1'b0;
    end else if (is_read && !rd_wait && req_ready) begin
      rd_wait <= 1'b1;
    end else if (rd_end) begin
      rd_wait <= 1'b0;
    end
  end

  // operand value and register word
  always_ff @(posedge clk) begin
    if (rd_end) begin
      value <= rsp_data;
      // indirect read keeps the address
      if (op == SLOT_READ) begin
        ptr <= rsp_data;
      end
    end else if (op == SLOT_CATCH) begin
      value <= catch_data;
      ptr   <= catch_data;
    end
  end

  // write data frozen for the whole write, the result pulse is short
  always_ff @(posedge clk) begin
    if (!is_write) begin
      wr_hold <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- source/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  mem_pkg::data_t    cmd_word,
  input  logic              cmd_done,
  input  logic              src1_done,
  input  logic              src0_done,
  input  logic              dst_done,
  input  logic              res_valid,
  output mem_pkg::slot_op_t cmd_op,
  output mem_pkg::slot_op_t src1_op,
  output mem_pkg::slot_op_t src0_op,
  output mem_pkg::slot_op_t dst_op,
  output logic              op_valid,
  output logic              halted
);
  import isa_pkg::*;
  import mem_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;

  reg_num_t  src1_num;
  reg_num_t  src0_num;
  logic      src1_ind;
  logic      src0_ind;
  logic      dst_ind;
  cmd_code_t code;
  logic      src1_catch;
  logic      src0_catch;

  // decode, valid from S_WRITE_IP on
  assign src1_num = cmd_word[SRC1_POS +: REG_W];
  assign src0_num = cmd_word[SRC0_POS +: REG_W];
  assign src1_ind = cmd_word[SRC1_PTR_POS];
  assign src0_ind = cmd_word[SRC0_PTR_POS];
  assign dst_ind  = cmd_word[DST_PTR_POS];
  assign code     = cmd_code_t'(cmd_word[CODE_POS +: CODE_W]);

  // no memory read when the word is already inside
  assign src1_catch = (src1_num == REG_IP);
  assign src0_catch = (src0_num == REG_IP) || (src0_num == src1_num);

  assign op_valid = (state == S_EXEC);
  assign halted   = (state == S_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_READ_IP;
    end else begin
      state <= state_nxt;
    end
  end

  // each step waits for its slot, exec waits for the result pulse
  always_comb begin
    state_nxt = state;
    case (state)
      S_READ_IP: if (cmd_done) state_nxt = S_FETCH;
      S_FETCH: if (cmd_done) state_nxt = S_WRITE_IP;
      S_WRITE_IP: begin
        // halt skips the ip write
        if (code == CMD_HALT) state_nxt = S_HALT;
        else if (cmd_done) state_nxt = S_SRC1;
      end
      S_SRC1: begin
        if (src1_done) state_nxt = src1_ind ? S_SRC1_P : S_SRC0;
      end
      S_SRC1_P: if (src1_done) state_nxt = S_SRC0;
      S_SRC0: begin
        if (src0_done) begin
          if (src0_ind) state_nxt = S_SRC0_P;
          else state_nxt = dst_ind ? S_DST : S_EXEC;
        end
      end
      S_SRC0_P: begin
        if (src0_done) state_nxt = dst_ind ? S_DST : S_EXEC;
      end
      // pointer dst, fetch the target address
      S_DST: if (dst_done) state_nxt = S_EXEC;
      S_EXEC: if (res_valid) state_nxt = S_WRITE_DST;
      S_WRITE_DST: if (dst_done) state_nxt = S_READ_IP;
      // left only by reset
      S_HALT: state_nxt = S_HALT;
      default: state_nxt = S_READ_IP;
    endcase
  end

  // one slot active per state
  always_comb begin
    cmd_op  = SLOT_NULL;
    src1_op = SLOT_NULL;
    src0_op = SLOT_NULL;
    dst_op  = SLOT_NULL;
    case (state)
      S_READ_IP: cmd_op = SLOT_READ;
      // command word through ip
      S_FETCH: cmd_op = SLOT_READ_P;
      S_WRITE_IP: cmd_op = (code == CMD_HALT) ? SLOT_NULL : SLOT_WRITE;
      S_SRC1: src1_op = src1_catch ? SLOT_CATCH : SLOT_READ;
      S_SRC1_P: src1_op = SLOT_READ_P;
      S_SRC0: src0_op = src0_catch ? SLOT_CATCH : SLOT_READ;
      S_SRC0_P: src0_op = SLOT_READ_P;
      S_DST: dst_op = SLOT_READ;
      S_WRITE_DST: dst_op = dst_ind ? SLOT_WRITE_P : SLOT_WRITE;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // memory bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // what one operand slot is told to do this cycle
  typedef enum logic [2:0] {
    SLOT_NULL,
    // register word into value and ptr
    SLOT_READ,
    // word at ptr into value
    SLOT_READ_P,
    // forwarded word into value and ptr
    SLOT_CATCH,
    SLOT_WRITE,
    SLOT_WRITE_P
  } slot_op_t;

  // command sequence, see mem_sequencer
  typedef enum logic [3:0] {
    S_READ_IP,
    S_FETCH,
    S_WRITE_IP,
    S_SRC1,
    S_SRC1_P,
    S_SRC0,
    S_SRC0_P,
    S_DST,
    S_EXEC,
    S_WRITE_DST,
    S_HALT
  } seq_state_t;

endpackage

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // register number, sixteen words in the memory register file
  localparam int REG_W = 4;
  typedef logic [REG_W-1:0] reg_num_t;

  // ip sits in the top register
  localparam reg_num_t REG_IP = 4'd15;

  // opcode field of the command word
  localparam int CODE_W = 4;

  // first four go to the executor as they are
  typedef enum logic [CODE_W-1:0] {
    CMD_MOV  = 4'h0,
    CMD_ADD  = 4'h1,
    CMD_SUB  = 4'h2,
    CMD_AND  = 4'h3,
    // stops fetching until reset
    CMD_HALT = 4'hf
  } cmd_code_t;

  // low bit of each command word field
  localparam int SRC1_POS     = 0;
  localparam int SRC0_POS     = 4;
  localparam int DST_POS      = 8;
  // pointer flags, one bit each
  localparam int SRC1_PTR_POS = 16;
  localparam int SRC0_PTR_POS = 17;
  localparam int DST_PTR_POS  = 18;
  // bits 31..28
  localparam int CODE_POS     = 28;

endpackage

`default_nettype wire
